// File: hdl/uart_pkg.sv
package uart_pkg;

	// Serial timing for a 50 MHz clock at 3.125 Mbaud
	localparam int CLKS_PER_BIT = 16;

	// FIFO depths given as address widths
	localparam int TX_FIFO_AW = 4;
	localparam int RX_FIFO_AW = 2;

	localparam int AXIL_AW = 4;

	// Register byte offsets
	localparam logic [AXIL_AW-1:0] REG_TXDATA = 4'h0;
	localparam logic [AXIL_AW-1:0] REG_RXDATA = 4'h4;
	localparam logic [AXIL_AW-1:0] REG_STATUS = 4'h8;

	// Bit positions in the status word
	localparam int STAT_TX_FULL = 0;
	localparam int STAT_TX_IDLE = 1;
	localparam int STAT_RX_EMPTY = 2;
	localparam int STAT_RX_OVERRUN = 3;

	// AXI response codes
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage : uart_pkg

// File: hdl/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
	parameter int AW = 2
) (
	input	logic			clk,
	input	logic			rst,
	input	logic			wr_en_i,
	input	logic	[7:0]	wr_data_i,
	input	logic			rd_en_i,
	output	logic	[7:0]	rd_data_o,
	output	logic			empty_o,
	output	logic			full_o
);

	logic	[7:0]	mem [2**AW];
	logic	[AW:0]	wr_ptr;
	logic	[AW:0]	rd_ptr;
	logic			do_wr;
	logic			do_rd;

	// Extra pointer bit tells full from empty
	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o = (wr_ptr[AW] != rd_ptr[AW]) &&
		(wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_wr = wr_en_i && !full_o;
	assign do_rd = rd_en_i && !empty_o;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= wr_data_i;
	end

	// Data shows up the cycle after the pop
	always_ff @(posedge clk) begin
		if (do_rd)
			rd_data_o <= mem[rd_ptr[AW-1:0]];
	end

endmodule : sync_fifo

// File: hdl/axil_to_simp.sv
`timescale 1ns/100ps

module axil_to_simp
	import uart_pkg::*;
(
	input	logic					clk,
	input	logic					rst,

	// AXI-lite slave
	input	logic					awvalid_i,
	input	logic	[AXIL_AW-1:0]	awaddr_i,
	input	logic					wvalid_i,
	input	logic	[31:0]			wdata_i,
	input	logic					arvalid_i,
	input	logic	[AXIL_AW-1:0]	araddr_i,
	input	logic					bready_i,
	input	logic					rready_i,
	output	logic					awready_o,
	output	logic					wready_o,
	output	logic					arready_o,
	output	logic					bvalid_o,
	output	logic	[1:0]			bresp_o,
	output	logic					rvalid_o,
	output	logic	[31:0]			rdata_o,
	output	logic	[1:0]			rresp_o,

	// Simple bus
	output	logic	[AXIL_AW-1:0]	simp_addr_o,
	output	logic	[31:0]			simp_wdata_o,
	output	logic					simp_wr_o,
	output	logic					simp_rd_o,
	output	logic					simp_valid_o,
	input	logic	[31:0]			simp_rdata_i,
	input	logic					simp_err_i,
	input	logic					simp_done_i
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ISSUE,
		S_WAIT,
		S_RESP
	} state_t;
	state_t state;

	logic					aw_held;
	logic					w_held;
	logic					is_wr;
	logic	[AXIL_AW-1:0]	addr_q;
	logic	[31:0]			wdata_q;
	logic	[31:0]			rdata_q;
	logic	[1:0]			resp_q;
	logic					aw_hs;
	logic					w_hs;
	logic					ar_hs;
	logic					aw_have;
	logic					w_have;

	assign aw_hs = awvalid_i && awready_o;
	assign w_hs = wvalid_i && wready_o;
	assign ar_hs = arvalid_i && arready_o;
	assign aw_have = aw_held || aw_hs;
	assign w_have = w_held || w_hs;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state <= S_IDLE;
			aw_held <= 1'b0;
			w_held <= 1'b0;
			is_wr <= 1'b0;
			awready_o <= 1'b0;
			wready_o <= 1'b0;
			arready_o <= 1'b0;
			simp_valid_o <= 1'b0;
			bvalid_o <= 1'b0;
			rvalid_o <= 1'b0;
			resp_q <= RESP_OKAY;
		end else begin
			awready_o <= 1'b0;
			wready_o <= 1'b0;
			arready_o <= 1'b0;
			simp_valid_o <= 1'b0;
			case (state)
				S_IDLE: begin
					if (aw_hs)
						aw_held <= 1'b1;
					if (w_hs)
						w_held <= 1'b1;
					if (aw_have && w_have) begin
						aw_held <= 1'b0;
						w_held <= 1'b0;
						is_wr <= 1'b1;
						state <= S_ISSUE;
					end else if (ar_hs) begin
						is_wr <= 1'b0;
						state <= S_ISSUE;
					end else begin
						awready_o <= awvalid_i && !aw_have && !awready_o && !arready_o;
						wready_o <= wvalid_i && !w_have && !wready_o && !arready_o;
						// Reads only get in when no write half is around
						arready_o <= arvalid_i && !arready_o && !aw_have && !w_have &&
							!awvalid_i && !wvalid_i && !awready_o && !wready_o;
					end
				end
				S_ISSUE: begin
					simp_valid_o <= 1'b1;
					state <= S_WAIT;
				end
				S_WAIT: begin
					if (simp_done_i) begin
						resp_q <= simp_err_i ? RESP_SLVERR : RESP_OKAY;
						bvalid_o <= is_wr;
						rvalid_o <= !is_wr;
						state <= S_RESP;
					end
				end
				S_RESP: begin
					if ((bvalid_o && bready_i) || (rvalid_o && rready_i)) begin
						bvalid_o <= 1'b0;
						rvalid_o <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && aw_hs)
			addr_q <= awaddr_i;
		else if (state == S_IDLE && ar_hs)
			addr_q <= araddr_i;
		if (state == S_IDLE && w_hs)
			wdata_q <= wdata_i;
		if (state == S_WAIT && simp_done_i)
			rdata_q <= simp_rdata_i;
	end

	assign simp_addr_o = addr_q;
	assign simp_wdata_o = wdata_q;
	assign simp_wr_o = is_wr;
	assign simp_rd_o = !is_wr;

	assign bresp_o = resp_q;
	assign rresp_o = resp_q;
	assign rdata_o = rdata_q;

endmodule : axil_to_simp

// File: hdl/uart_core.sv
`timescale 1ns/100ps

module uart_core
	import uart_pkg::*;
(
	input	logic			clk,
	input	logic			rst,
	input	logic			rx_i,
	input	logic			tx_start_i,
	input	logic	[7:0]	tx_byte_i,
	output	logic			tx_o,
	output	logic			tx_busy_o,
	output	logic			tx_done_o,
	output	logic			rx_valid_o,
	output	logic	[7:0]	rx_byte_o
);

	localparam int CW = $clog2(CLKS_PER_BIT);
	localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] BIT_HALF = CW'(CLKS_PER_BIT / 2 - 1);

	// Transmitter
	logic	[9:0]		tx_shift;
	logic	[CW-1:0]	tx_cnt;
	logic	[3:0]		tx_bit;

	// Idle shifter is all ones so the line rests high
	assign tx_o = tx_shift[0];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			tx_shift <= '1;
			tx_cnt <= '0;
			tx_bit <= '0;
			tx_busy_o <= 1'b0;
			tx_done_o <= 1'b0;
		end else begin
			tx_done_o <= 1'b0;
			if (!tx_busy_o) begin
				if (tx_start_i) begin
					tx_shift <= {1'b1, tx_byte_i, 1'b0};
					tx_cnt <= '0;
					tx_bit <= '0;
					tx_busy_o <= 1'b1;
				end
			end else if (tx_cnt == BIT_LAST) begin
				tx_cnt <= '0;
				tx_shift <= {1'b1, tx_shift[9:1]};
				// Stop bit finished
				if (tx_bit == 4'd9) begin
					tx_busy_o <= 1'b0;
					tx_done_o <= 1'b1;
				end else begin
					tx_bit <= tx_bit + 4'd1;
				end
			end else begin
				tx_cnt <= tx_cnt + 1'b1;
			end
		end
	end

	// Receiver
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;
	rx_state_t rx_state;

	logic				rx_meta;
	logic				rx_sync;
	logic				rx_prev;
	logic				rx_fall;
	logic	[CW-1:0]	rx_cnt;
	logic	[2:0]		rx_bit;
	logic	[7:0]		rx_shift;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_i;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign rx_fall = rx_prev && !rx_sync;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			rx_state <= RX_IDLE;
			rx_cnt <= '0;
			rx_bit <= '0;
			rx_valid_o <= 1'b0;
		end else begin
			rx_valid_o <= 1'b0;
			case (rx_state)
				RX_IDLE: begin
					rx_cnt <= '0;
					if (rx_fall)
						rx_state <= RX_START;
				end
				RX_START: begin
					if (rx_cnt == BIT_HALF) begin
						rx_cnt <= '0;
						rx_bit <= '0;
						// Start bit gone high again means a glitch
						rx_state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				RX_DATA: begin
					if (rx_cnt == BIT_LAST) begin
						rx_cnt <= '0;
						rx_bit <= rx_bit + 3'd1;
						if (rx_bit == 3'd7)
							rx_state <= RX_STOP;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				RX_STOP: begin
					if (rx_cnt == BIT_LAST) begin
						rx_cnt <= '0;
						rx_valid_o <= rx_sync;
						rx_state <= RX_IDLE;
					end else begin
						rx_cnt <= rx_cnt + 1'b1;
					end
				end
				default: rx_state <= RX_IDLE;
			endcase
		end
	end

	// LSB arrives first
	always_ff @(posedge clk) begin
		if (rx_state == RX_DATA && rx_cnt == BIT_LAST)
			rx_shift <= {rx_sync, rx_shift[7:1]};
		if (rx_state == RX_STOP && rx_cnt == BIT_LAST && rx_sync)
			rx_byte_o <= rx_shift;
	end

endmodule : uart_core

// File: hdl/uart_axil.sv
`timescale 1ns/100ps

module uart_axil
	import uart_pkg::*;
(
	input	logic					clk,
	input	logic					rst,

	// AXI-lite slave
	input	logic					awvalid_i,
	input	logic	[AXIL_AW-1:0]	awaddr_i,
	input	logic					wvalid_i,
	input	logic	[31:0]			wdata_i,
	input	logic					arvalid_i,
	input	logic	[AXIL_AW-1:0]	araddr_i,
	input	logic					bready_i,
	input	logic					rready_i,
	output	logic					awready_o,
	output	logic					wready_o,
	output	logic					arready_o,
	output	logic					bvalid_o,
	output	logic	[1:0]			bresp_o,
	output	logic					rvalid_o,
	output	logic	[31:0]			rdata_o,
	output	logic	[1:0]			rresp_o,

	// Serial lines
	input	logic					uart_rx_i,
	output	logic					uart_tx_o
);

	logic	[AXIL_AW-1:0]	simp_addr;
	logic	[31:0]			simp_wdata;
	logic					simp_wr;
	logic					simp_rd;
	logic					simp_valid;
	logic	[31:0]			simp_rdata;
	logic					simp_err;
	logic					simp_done;

	logic			tx_wr_en;
	logic			tx_rd_en;
	logic	[7:0]	tx_rd_data;
	logic			tx_empty;
	logic			tx_full;
	logic			rx_rd_en;
	logic	[7:0]	rx_rd_data;
	logic			rx_empty;
	logic			rx_full;

	logic			tx_start;
	logic			tx_busy;
	logic			tx_done;
	logic			rx_valid;
	logic	[7:0]	rx_byte;

	logic			overrun;
	logic			tx_idle;
	logic	[3:0]	status;

	axil_to_simp u_bridge (
		.clk			(clk),
		.rst			(rst),
		.awvalid_i		(awvalid_i),
		.awaddr_i		(awaddr_i),
		.wvalid_i		(wvalid_i),
		.wdata_i		(wdata_i),
		.arvalid_i		(arvalid_i),
		.araddr_i		(araddr_i),
		.bready_i		(bready_i),
		.rready_i		(rready_i),
		.awready_o		(awready_o),
		.wready_o		(wready_o),
		.arready_o		(arready_o),
		.bvalid_o		(bvalid_o),
		.bresp_o		(bresp_o),
		.rvalid_o		(rvalid_o),
		.rdata_o		(rdata_o),
		.rresp_o		(rresp_o),
		.simp_addr_o	(simp_addr),
		.simp_wdata_o	(simp_wdata),
		.simp_wr_o		(simp_wr),
		.simp_rd_o		(simp_rd),
		.simp_valid_o	(simp_valid),
		.simp_rdata_i	(simp_rdata),
		.simp_err_i		(simp_err),
		.simp_done_i	(simp_done)
	);

	// Register FSM where each state after idle is the one-cycle reply
	typedef enum logic [2:0] {
		R_IDLE,
		R_OK,
		R_POP,
		R_STATUS,
		R_ERR
	} reg_state_t;
	reg_state_t reg_state, reg_state_nxt;

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			reg_state <= R_IDLE;
		else
			reg_state <= reg_state_nxt;
	end

	always_comb begin
		reg_state_nxt = R_IDLE;
		tx_wr_en = 1'b0;
		rx_rd_en = 1'b0;
		if (reg_state == R_IDLE && simp_valid) begin
			if (simp_wr) begin
				if (simp_addr == REG_TXDATA && !tx_full) begin
					tx_wr_en = 1'b1;
					reg_state_nxt = R_OK;
				end else begin
					reg_state_nxt = R_ERR;
				end
			end else if (simp_rd) begin
				case (simp_addr)
					REG_TXDATA: reg_state_nxt = R_OK;
					REG_RXDATA: begin
						rx_rd_en = !rx_empty;
						reg_state_nxt = rx_empty ? R_OK : R_POP;
					end
					REG_STATUS: reg_state_nxt = R_STATUS;
					default: reg_state_nxt = R_ERR;
				endcase
			end
		end
	end

	always_comb begin
		status = '0;
		status[STAT_TX_FULL] = tx_full;
		status[STAT_TX_IDLE] = tx_idle;
		status[STAT_RX_EMPTY] = rx_empty;
		status[STAT_RX_OVERRUN] = overrun;
	end

	always_comb begin
		case (reg_state)
			R_POP: simp_rdata = {23'd0, 1'b1, rx_rd_data};
			R_STATUS: simp_rdata = {28'd0, status};
			default: simp_rdata = '0;
		endcase
	end

	assign simp_done = (reg_state != R_IDLE);
	assign simp_err = (reg_state == R_ERR);

	// Sticky until a status read but a new loss wins
	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			overrun <= 1'b0;
		else if (rx_valid && rx_full)
			overrun <= 1'b1;
		else if (reg_state == R_STATUS)
			overrun <= 1'b0;
	end

	// Transmit feeder
	typedef enum logic [1:0] {
		F_IDLE,
		F_LOAD,
		F_SEND
	} feed_state_t;
	feed_state_t feed_state, feed_state_nxt;

	assign tx_idle = tx_empty && !tx_busy && (feed_state == F_IDLE);

	always_ff @(posedge clk, posedge rst) begin
		if (rst)
			feed_state <= F_IDLE;
		else
			feed_state <= feed_state_nxt;
	end

	always_comb begin
		feed_state_nxt = feed_state;
		tx_rd_en = 1'b0;
		tx_start = 1'b0;
		case (feed_state)
			F_IDLE: begin
				if (!tx_empty && !tx_busy) begin
					tx_rd_en = 1'b1;
					feed_state_nxt = F_LOAD;
				end
			end
			F_LOAD: begin
				tx_start = 1'b1;
				feed_state_nxt = F_SEND;
			end
			F_SEND: begin
				if (tx_done)
					feed_state_nxt = F_IDLE;
			end
			default: feed_state_nxt = F_IDLE;
		endcase
	end

	sync_fifo #(
		.AW			(TX_FIFO_AW)
	) u_tx_fifo (
		.clk		(clk),
		.rst		(rst),
		.wr_en_i	(tx_wr_en),
		.wr_data_i	(simp_wdata[7:0]),
		.rd_en_i	(tx_rd_en),
		.rd_data_o	(tx_rd_data),
		.empty_o	(tx_empty),
		.full_o		(tx_full)
	);

	// FIFO drops the byte itself when full
	sync_fifo #(
		.AW			(RX_FIFO_AW)
	) u_rx_fifo (
		.clk		(clk),
		.rst		(rst),
		.wr_en_i	(rx_valid),
		.wr_data_i	(rx_byte),
		.rd_en_i	(rx_rd_en),
		.rd_data_o	(rx_rd_data),
		.empty_o	(rx_empty),
		.full_o		(rx_full)
	);

	uart_core u_core (
		.clk			(clk),
		.rst			(rst),
		.rx_i			(uart_rx_i),
		.tx_start_i		(tx_start),
		.tx_byte_i		(tx_rd_data),
		.tx_o			(uart_tx_o),
		.tx_busy_o		(tx_busy),
		.tx_done_o		(tx_done),
		.rx_valid_o		(rx_valid),
		.rx_byte_o		(rx_byte)
	);

endmodule : uart_axil

// File: tests/tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
	parameter real PERIOD_NS = 10.0
) (
	output	logic	clk_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
	end

endmodule : tb_clkgen

// File: tests/uart_axil_sva.sv
`timescale 1ns/100ps

module uart_axil_sva (
	input	logic			clk,
	input	logic			rst,
	input	logic			bvalid_i,
	input	logic			bready_i,
	input	logic	[1:0]	bresp_i,
	input	logic			rvalid_i,
	input	logic			rready_i,
	input	logic	[31:0]	rdata_i,
	input	logic	[1:0]	rresp_i,
	input	logic			tx_i,
	input	logic			tx_idle_i
);

	// Read by the testbench at the end of the run
	int fail_count = 0;

	b_held: assert property (@(posedge clk) disable iff (rst)
		bvalid_i && !bready_i |=> bvalid_i)
		else begin
			$error("bvalid_o dropped before bready_i");
			fail_count++;
		end

	b_stable: assert property (@(posedge clk) disable iff (rst)
		bvalid_i && !bready_i |=> $stable(bresp_i))
		else begin
			$error("bresp_o changed while the write response was held");
			fail_count++;
		end

	r_held: assert property (@(posedge clk) disable iff (rst)
		rvalid_i && !rready_i |=> rvalid_i)
		else begin
			$error("rvalid_o dropped before rready_i");
			fail_count++;
		end

	r_stable: assert property (@(posedge clk) disable iff (rst)
		rvalid_i && !rready_i |=> $stable({rdata_i, rresp_i}))
		else begin
			$error("rdata_o or rresp_o changed while the read response was held");
			fail_count++;
		end

	// Line rests high whenever nothing is queued or sending
	tx_rest: assert property (@(posedge clk) disable iff (rst)
		tx_idle_i |-> tx_i)
		else begin
			$error("uart_tx_o low while the transmitter is idle");
			fail_count++;
		end

endmodule : uart_axil_sva

// File: tests/tb_uart_axil.sv
`timescale 1ns/100ps

module tb_uart_axil
	import uart_pkg::*;
();

	localparam int CLK_NS = 10;
	localparam int RESET_CYCLES = 16;
	localparam int RESP_LATENCY = 3;
	localparam int FRAME_CYCLES = 10 * CLKS_PER_BIT;
	localparam int RX_DEPTH = 2 ** RX_FIFO_AW;
	// Frames in transmit, receive, overrun and back-pressure tests
	localparam int NUM_FRAMES = 3 + 2 + (RX_DEPTH + 1) + 1;
	localparam int MARGIN_CYCLES = 2000;
	localparam int WATCHDOG_NS =
		(RESET_CYCLES + NUM_FRAMES * (FRAME_CYCLES + 8) + MARGIN_CYCLES) * CLK_NS;
	localparam int START_WAIT_CYCLES = 4 * FRAME_CYCLES;
	localparam logic [31:0] STATUS_IDLE =
		(32'd1 << STAT_TX_IDLE) | (32'd1 << STAT_RX_EMPTY);
	localparam logic [31:0] STATUS_OVERRUN =
		(32'd1 << STAT_TX_IDLE) | (32'd1 << STAT_RX_OVERRUN);
	localparam logic [31:0] STATUS_HELD =
		(32'd1 << STAT_TX_IDLE);

	logic					clk;
	logic					rst;
	logic					awvalid;
	logic	[AXIL_AW-1:0]	awaddr;
	logic					wvalid;
	logic	[31:0]			wdata;
	logic					arvalid;
	logic	[AXIL_AW-1:0]	araddr;
	logic					bready;
	logic					rready;
	logic					awready;
	logic					wready;
	logic					arready;
	logic					bvalid;
	logic	[1:0]			bresp;
	logic					rvalid;
	logic	[31:0]			rdata;
	logic	[1:0]			rresp;
	logic					uart_rx;
	logic					uart_tx;

	int seed = 32'h741;
	int errors = 0;
	int checks = 0;
	int test_start_errors = 0;

	tb_clkgen #(
		.PERIOD_NS	(10.0)
	) u_clkgen (
		.clk_o		(clk)
	);

	uart_axil u_uart_axil (
		.clk		(clk),
		.rst		(rst),
		.awvalid_i	(awvalid),
		.awaddr_i	(awaddr),
		.wvalid_i	(wvalid),
		.wdata_i	(wdata),
		.arvalid_i	(arvalid),
		.araddr_i	(araddr),
		.bready_i	(bready),
		.rready_i	(rready),
		.awready_o	(awready),
		.wready_o	(wready),
		.arready_o	(arready),
		.bvalid_o	(bvalid),
		.bresp_o	(bresp),
		.rvalid_o	(rvalid),
		.rdata_o	(rdata),
		.rresp_o	(rresp),
		.uart_rx_i	(uart_rx),
		.uart_tx_o	(uart_tx)
	);

	bind uart_axil uart_axil_sva u_sva (
		.clk		(clk),
		.rst		(rst),
		.bvalid_i	(bvalid_o),
		.bready_i	(bready_i),
		.bresp_i	(bresp_o),
		.rvalid_i	(rvalid_o),
		.rready_i	(rready_i),
		.rdata_i	(rdata_o),
		.rresp_i	(rresp_o),
		.tx_i		(uart_tx_o),
		.tx_idle_i	(tx_idle)
	);

	// Moves to 1 ns after a later rising edge
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("Error at time %0t: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic require(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			$display("Failure at time %0t: %s", $time, what);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("Test %s done, %0d errors", name, errors - test_start_errors);
		test_start_errors = errors;
	endtask

	task automatic write_reg(input logic [AXIL_AW-1:0] addr, input logic [31:0] data,
		input int hold_cycles, output logic [1:0] resp);
		bit aw_seen;
		bit w_seen;
		int lat;
		logic [1:0] held_resp;
		awvalid = 1'b1;
		awaddr = addr;
		wvalid = 1'b1;
		wdata = data;
		while (awvalid || wvalid) begin
			aw_seen = awvalid && awready;
			w_seen = wvalid && wready;
			wait_cycles(1);
			if (aw_seen)
				awvalid = 1'b0;
			if (w_seen)
				wvalid = 1'b0;
		end
		lat = 0;
		while (!bvalid) begin
			wait_cycles(1);
			lat++;
		end
		compare_value("write response latency", lat, RESP_LATENCY);
		held_resp = bresp;
		repeat (hold_cycles) begin
			wait_cycles(1);
			compare_value("bvalid_o", bvalid, 1'b1);
			compare_value("bresp_o", bresp, held_resp);
		end
		resp = bresp;
		bready = 1'b1;
		wait_cycles(1);
		bready = 1'b0;
		compare_value("bvalid_o", bvalid, 1'b0);
	endtask

	task automatic read_reg(input logic [AXIL_AW-1:0] addr, input int hold_cycles,
		output logic [31:0] data, output logic [1:0] resp);
		bit ar_seen;
		int lat;
		logic [31:0] held_data;
		logic [1:0] held_resp;
		arvalid = 1'b1;
		araddr = addr;
		ar_seen = 1'b0;
		while (!ar_seen) begin
			ar_seen = arready;
			wait_cycles(1);
		end
		arvalid = 1'b0;
		lat = 0;
		while (!rvalid) begin
			wait_cycles(1);
			lat++;
		end
		compare_value("read response latency", lat, RESP_LATENCY);
		held_data = rdata;
		held_resp = rresp;
		repeat (hold_cycles) begin
			wait_cycles(1);
			compare_value("rvalid_o", rvalid, 1'b1);
			compare_value("rdata_o", rdata, held_data);
			compare_value("rresp_o", rresp, held_resp);
		end
		data = rdata;
		resp = rresp;
		rready = 1'b1;
		wait_cycles(1);
		rready = 1'b0;
		compare_value("rvalid_o", rvalid, 1'b0);
	endtask

	// Start bit, LSB first, stop bit, then a short idle gap
	task automatic send_serial(input logic [7:0] b);
		int i;
		uart_rx = 1'b0;
		wait_cycles(CLKS_PER_BIT);
		for (i = 0; i < 8; i++) begin
			uart_rx = b[i];
			wait_cycles(CLKS_PER_BIT);
		end
		uart_rx = 1'b1;
		wait_cycles(CLKS_PER_BIT + 4);
	endtask

	task automatic capture_frame(output logic [7:0] b);
		int n;
		int i;
		n = 0;
		b = '0;
		while (uart_tx && n < START_WAIT_CYCLES) begin
			wait_cycles(1);
			n++;
		end
		require(!uart_tx, "no start bit seen on uart_tx_o");
		wait_cycles(CLKS_PER_BIT / 2);
		compare_value("uart_tx_o start bit", uart_tx, 1'b0);
		for (i = 0; i < 8; i++) begin
			wait_cycles(CLKS_PER_BIT);
			b[i] = uart_tx;
		end
		wait_cycles(CLKS_PER_BIT);
		compare_value("uart_tx_o stop bit", uart_tx, 1'b1);
		wait_cycles(CLKS_PER_BIT / 2 + 1);
	endtask

	task automatic after_reset_status();
		logic [31:0] rd;
		logic [1:0] resp;
		require(uart_tx === 1'b1, "uart_tx_o is not high after reset");
		compare_value("awready_o", awready, 1'b0);
		compare_value("wready_o", wready, 1'b0);
		compare_value("arready_o", arready, 1'b0);
		compare_value("bvalid_o", bvalid, 1'b0);
		compare_value("rvalid_o", rvalid, 1'b0);
		read_reg(REG_STATUS, 0, rd, resp);
		compare_value("status", rd, STATUS_IDLE);
		compare_value("rresp_o", resp, RESP_OKAY);
		read_reg(REG_RXDATA, 0, rd, resp);
		compare_value("rxdata", rd, 32'd0);
		compare_value("rresp_o", resp, RESP_OKAY);
		report_test("reset");
	endtask

	task automatic transmit_three_bytes();
		logic [31:0] words [3];
		logic [31:0] rd;
		logic [7:0] got;
		logic [1:0] resp;
		int j;
		int k;
		for (j = 0; j < 3; j++)
			words[j] = $random(seed);
		fork
			begin
				for (j = 0; j < 3; j++) begin
					write_reg(REG_TXDATA, words[j], 0, resp);
					compare_value("bresp_o", resp, RESP_OKAY);
				end
			end
			begin
				for (k = 0; k < 3; k++) begin
					capture_frame(got);
					compare_value("uart_tx_o byte", got, words[k][7:0]);
				end
			end
		join
		read_reg(REG_STATUS, 0, rd, resp);
		compare_value("status", rd, STATUS_IDLE);
		report_test("transmit");
	endtask

	task automatic receive_two_bytes();
		logic [7:0] bytes [2];
		logic [31:0] rd;
		logic [1:0] resp;
		int j;
		for (j = 0; j < 2; j++) begin
			bytes[j] = $random(seed);
			send_serial(bytes[j]);
		end
		for (j = 0; j < 2; j++) begin
			read_reg(REG_RXDATA, 0, rd, resp);
			compare_value("rxdata", rd, 32'h100 | bytes[j]);
			compare_value("rresp_o", resp, RESP_OKAY);
		end
		read_reg(REG_RXDATA, 0, rd, resp);
		compare_value("rxdata when empty", rd, 32'd0);
		report_test("receive");
	endtask

	task automatic rx_overrun();
		logic [7:0] bytes [RX_DEPTH + 1];
		logic [31:0] rd;
		logic [1:0] resp;
		int j;
		for (j = 0; j <= RX_DEPTH; j++) begin
			bytes[j] = $random(seed);
			send_serial(bytes[j]);
		end
		read_reg(REG_STATUS, 0, rd, resp);
		compare_value("status after overrun", rd, STATUS_OVERRUN);
		read_reg(REG_STATUS, 0, rd, resp);
		compare_value("status after clear", rd, STATUS_HELD);
		for (j = 0; j < RX_DEPTH; j++) begin
			read_reg(REG_RXDATA, 0, rd, resp);
			compare_value("rxdata", rd, 32'h100 | bytes[j]);
		end
		// The extra byte was dropped
		read_reg(REG_RXDATA, 0, rd, resp);
		compare_value("rxdata when empty", rd, 32'd0);
		report_test("overrun");
	endtask

	task automatic errors_and_backpressure();
		logic [31:0] word;
		logic [31:0] rd;
		logic [7:0] got;
		logic [1:0] resp;
		word = $random(seed);
		write_reg(REG_STATUS, word, 0, resp);
		compare_value("bresp_o for status write", resp, RESP_SLVERR);
		read_reg(4'hc, 0, rd, resp);
		compare_value("rresp_o for unmapped read", resp, RESP_SLVERR);
		compare_value("rdata_o for unmapped read", rd, 32'd0);
		fork
			begin
				write_reg(REG_TXDATA, word, 6, resp);
				compare_value("bresp_o after hold", resp, RESP_OKAY);
			end
			begin
				capture_frame(got);
				compare_value("uart_tx_o byte", got, word[7:0]);
			end
		join
		read_reg(REG_STATUS, 6, rd, resp);
		compare_value("status after held read", rd, STATUS_IDLE);
		compare_value("rresp_o after held read", resp, RESP_OKAY);
		report_test("errors");
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		arvalid = 1'b0;
		araddr = '0;
		bready = 1'b0;
		rready = 1'b0;
		uart_rx = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		wait_cycles(2);
		after_reset_status();
		transmit_three_bytes();
		receive_two_bytes();
		rx_overrun();
		errors_and_backpressure();
		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, u_uart_axil.u_sva.fail_count);
		if (errors == 0 && u_uart_axil.u_sva.fail_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule : tb_uart_axil

// File: sources.f
hdl/uart_pkg.sv
hdl/sync_fifo.sv
hdl/axil_to_simp.sv
hdl/uart_core.sv
hdl/uart_axil.sv
tests/tb_clkgen.sv
tests/uart_axil_sva.sv
tests/tb_uart_axil.sv
